// ==== hdl/mipsIsaPkg.sv ====
package mipsIsaPkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LB      = 6'b100000,
		OP_LH      = 6'b100001,
		OP_LW      = 6'b100011,
		OP_LBU     = 6'b100100,
		OP_LHU     = 6'b100101,
		OP_SB      = 6'b101000,
		OP_SH      = 6'b101001,
		OP_SW      = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL     = 6'b000000,
		FN_SRL     = 6'b000010,
		FN_SRA     = 6'b000011,
		FN_SLLV    = 6'b000100,
		FN_SRLV    = 6'b000110,
		FN_SRAV    = 6'b000111,
		FN_JR      = 6'b001000,
		FN_JALR    = 6'b001001,
		FN_SYSCALL = 6'b001100,
		FN_BREAK   = 6'b001101,
		FN_MFHI    = 6'b010000,
		FN_MTHI    = 6'b010001,
		FN_MFLO    = 6'b010010,
		FN_MTLO    = 6'b010011,
		FN_MULT    = 6'b011000,
		FN_MULTU   = 6'b011001,
		FN_DIV     = 6'b011010,
		FN_DIVU    = 6'b011011,
		FN_ADD     = 6'b100000,
		FN_ADDU    = 6'b100001,
		FN_SUB     = 6'b100010,
		FN_SUBU    = 6'b100011,
		FN_AND     = 6'b100100,
		FN_OR      = 6'b100101,
		FN_XOR     = 6'b100110,
		FN_NOR     = 6'b100111,
		FN_SLT     = 6'b101010,
		FN_SLTU    = 6'b101011
	} funct_t;

	// rt field codes under OP_REGIMM
	typedef enum logic [4:0] {
		RT_BLTZ    = 5'b00000,
		RT_BGEZ    = 5'b00001,
		RT_BLTZAL  = 5'b10000,
		RT_BGEZAL  = 5'b10001
	} regimm_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrFields_t;

	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10
	} excCode_t;

	localparam logic [4:0] LINK_REG = 5'd31; // Return address register

endpackage

// ==== hdl/decodeCtrlPkg.sv ====
package decodeCtrlPkg;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_LUI,
		ALU_NONE
	} aluOp_t;

	typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extOp_t;

	typedef enum logic [2:0] {
		HILO_NONE, HILO_MULT, HILO_MULTU, HILO_DIV, HILO_DIVU, HILO_MTHI, HILO_MTLO
	} hiLoOp_t;

	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} memSize_t;

	typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_JREG} npcOp_t;

	typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} regDst_t;

	typedef enum logic [2:0] {WB_ALU, WB_HI, WB_LO, WB_LINK, WB_MEM} wbSrc_t;

	// Sign of rs as seen by the compare unit
	typedef enum logic [1:0] {
		SIGN_ZERO = 2'b00,
		SIGN_POS  = 2'b01,
		SIGN_NEG  = 2'b10
	} sign_t;

	typedef struct packed {
		logic  neq; // rs != rt
		sign_t sign;
	} cmpFlags_t;

	typedef struct packed {
		aluOp_t  aluOp;
		extOp_t  extOp;
		logic    shamtSel; // Shift amount from instr
		hiLoOp_t hiLoOp;
	} aluCtrl_t;

	typedef struct packed {
		logic     read;
		logic     write;
		memSize_t size;
		logic     isSigned;
	} memCtrl_t;

	typedef struct packed {
		logic   isBranch;
		npcOp_t npcOp;
	} branchCtrl_t;

	typedef struct packed {
		logic    regWrite;
		regDst_t regDst;
		wbSrc_t  wbSrc;
	} wbCtrl_t;

	typedef struct packed {
		logic                 valid;
		mipsIsaPkg::excCode_t code;
	} excInfo_t;

	typedef struct packed {
		aluCtrl_t    alu;
		memCtrl_t    mem;
		branchCtrl_t branch;
		wbCtrl_t     wb;
		excInfo_t    exc;
	} decodeCtrl_t;

endpackage

// ==== hdl/aluDecoder.sv ====
`timescale 1ns/100ps

module aluDecoder (
	input  mipsIsaPkg::instrFields_t instr,
	output decodeCtrlPkg::aluCtrl_t  aluCtrl
);

	logic isSpecial;

	assign isSpecial = instr.op == mipsIsaPkg::OP_SPECIAL;

	always_comb begin
		aluCtrl.aluOp = decodeCtrlPkg::ALU_NONE;
		aluCtrl.hiLoOp = decodeCtrlPkg::HILO_NONE;
		case (instr.op)
			mipsIsaPkg::OP_SPECIAL: begin
				case (instr.funct)
					mipsIsaPkg::FN_ADD: aluCtrl.aluOp = decodeCtrlPkg::ALU_ADD;
					mipsIsaPkg::FN_ADDU: aluCtrl.aluOp = decodeCtrlPkg::ALU_ADDU;
					mipsIsaPkg::FN_SUB: aluCtrl.aluOp = decodeCtrlPkg::ALU_SUB;
					mipsIsaPkg::FN_SUBU: aluCtrl.aluOp = decodeCtrlPkg::ALU_SUBU;
					mipsIsaPkg::FN_AND: aluCtrl.aluOp = decodeCtrlPkg::ALU_AND;
					mipsIsaPkg::FN_OR: aluCtrl.aluOp = decodeCtrlPkg::ALU_OR;
					mipsIsaPkg::FN_XOR: aluCtrl.aluOp = decodeCtrlPkg::ALU_XOR;
					mipsIsaPkg::FN_NOR: aluCtrl.aluOp = decodeCtrlPkg::ALU_NOR;
					mipsIsaPkg::FN_SLL, mipsIsaPkg::FN_SLLV: aluCtrl.aluOp = decodeCtrlPkg::ALU_SLL;
					mipsIsaPkg::FN_SRL, mipsIsaPkg::FN_SRLV: aluCtrl.aluOp = decodeCtrlPkg::ALU_SRL;
					mipsIsaPkg::FN_SRA, mipsIsaPkg::FN_SRAV: aluCtrl.aluOp = decodeCtrlPkg::ALU_SRA;
					mipsIsaPkg::FN_SLT: aluCtrl.aluOp = decodeCtrlPkg::ALU_SLT;
					mipsIsaPkg::FN_SLTU: aluCtrl.aluOp = decodeCtrlPkg::ALU_SLTU;
					mipsIsaPkg::FN_MULT: aluCtrl.hiLoOp = decodeCtrlPkg::HILO_MULT;
					mipsIsaPkg::FN_MULTU: aluCtrl.hiLoOp = decodeCtrlPkg::HILO_MULTU;
					mipsIsaPkg::FN_DIV: aluCtrl.hiLoOp = decodeCtrlPkg::HILO_DIV;
					mipsIsaPkg::FN_DIVU: aluCtrl.hiLoOp = decodeCtrlPkg::HILO_DIVU;
					mipsIsaPkg::FN_MTHI: aluCtrl.hiLoOp = decodeCtrlPkg::HILO_MTHI;
					mipsIsaPkg::FN_MTLO: aluCtrl.hiLoOp = decodeCtrlPkg::HILO_MTLO;
					default: ;
				endcase
			end
			mipsIsaPkg::OP_ADDI: aluCtrl.aluOp = decodeCtrlPkg::ALU_ADD;
			mipsIsaPkg::OP_ADDIU: aluCtrl.aluOp = decodeCtrlPkg::ALU_ADDU;
			mipsIsaPkg::OP_SLTI: aluCtrl.aluOp = decodeCtrlPkg::ALU_SLT;
			mipsIsaPkg::OP_SLTIU: aluCtrl.aluOp = decodeCtrlPkg::ALU_SLTU;
			mipsIsaPkg::OP_ANDI: aluCtrl.aluOp = decodeCtrlPkg::ALU_AND;
			mipsIsaPkg::OP_ORI: aluCtrl.aluOp = decodeCtrlPkg::ALU_OR;
			mipsIsaPkg::OP_XORI: aluCtrl.aluOp = decodeCtrlPkg::ALU_XOR;
			mipsIsaPkg::OP_LUI: aluCtrl.aluOp = decodeCtrlPkg::ALU_LUI;
			mipsIsaPkg::OP_LB, mipsIsaPkg::OP_LBU, mipsIsaPkg::OP_LH, mipsIsaPkg::OP_LHU,
			mipsIsaPkg::OP_LW, mipsIsaPkg::OP_SB, mipsIsaPkg::OP_SH, mipsIsaPkg::OP_SW:
				aluCtrl.aluOp = decodeCtrlPkg::ALU_ADD; // Address = base + offset
			default: ;
		endcase
	end

	always_comb begin
		case (instr.op)
			mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI, mipsIsaPkg::OP_XORI:
				aluCtrl.extOp = decodeCtrlPkg::EXT_ZERO; // Logic immediates
			mipsIsaPkg::OP_LUI: aluCtrl.extOp = decodeCtrlPkg::EXT_UPPER;
			default: aluCtrl.extOp = decodeCtrlPkg::EXT_SIGN;
		endcase
	end

	// Constant shifts take shamt, the variable forms take rs
	assign aluCtrl.shamtSel = isSpecial && (instr.funct == mipsIsaPkg::FN_SLL
		|| instr.funct == mipsIsaPkg::FN_SRL || instr.funct == mipsIsaPkg::FN_SRA);

endmodule

// ==== hdl/memDecoder.sv ====
`timescale 1ns/100ps

module memDecoder (
	input  mipsIsaPkg::instrFields_t instr,
	output decodeCtrlPkg::memCtrl_t  memCtrl
);

	assign memCtrl.read = instr.op inside {mipsIsaPkg::OP_LB, mipsIsaPkg::OP_LBU,
		mipsIsaPkg::OP_LH, mipsIsaPkg::OP_LHU, mipsIsaPkg::OP_LW};
	assign memCtrl.write = instr.op inside {mipsIsaPkg::OP_SB, mipsIsaPkg::OP_SH,
		mipsIsaPkg::OP_SW};
	assign memCtrl.isSigned = instr.op == mipsIsaPkg::OP_LB || instr.op == mipsIsaPkg::OP_LH;

	always_comb begin
		case (instr.op)
			mipsIsaPkg::OP_LH, mipsIsaPkg::OP_LHU, mipsIsaPkg::OP_SH:
				memCtrl.size = decodeCtrlPkg::MEM_HALF;
			mipsIsaPkg::OP_LW, mipsIsaPkg::OP_SW:
				memCtrl.size = decodeCtrlPkg::MEM_WORD;
			default: memCtrl.size = decodeCtrlPkg::MEM_BYTE; // Also LB, LBU, SB
		endcase
	end

endmodule

// ==== hdl/branchResolver.sv ====
`timescale 1ns/100ps

module branchResolver (
	input  mipsIsaPkg::instrFields_t   instr,
	input  decodeCtrlPkg::cmpFlags_t   cmp,
	output decodeCtrlPkg::branchCtrl_t branchCtrl
);

	logic isNeg;
	logic isPos;

	assign isNeg = cmp.sign == decodeCtrlPkg::SIGN_NEG;
	assign isPos = cmp.sign == decodeCtrlPkg::SIGN_POS;

	always_comb begin
		branchCtrl.isBranch = 1'b0;
		branchCtrl.npcOp = decodeCtrlPkg::NPC_SEQ; // Not taken falls through
		case (instr.op)
			mipsIsaPkg::OP_BEQ: begin
				branchCtrl.isBranch = 1'b1;
				if (!cmp.neq) branchCtrl.npcOp = decodeCtrlPkg::NPC_BRANCH;
			end
			mipsIsaPkg::OP_BNE: begin
				branchCtrl.isBranch = 1'b1;
				if (cmp.neq) branchCtrl.npcOp = decodeCtrlPkg::NPC_BRANCH;
			end
			mipsIsaPkg::OP_BLEZ: begin
				branchCtrl.isBranch = 1'b1;
				if (!isPos) branchCtrl.npcOp = decodeCtrlPkg::NPC_BRANCH;
			end
			mipsIsaPkg::OP_BGTZ: begin
				branchCtrl.isBranch = 1'b1;
				if (isPos) branchCtrl.npcOp = decodeCtrlPkg::NPC_BRANCH;
			end
			mipsIsaPkg::OP_REGIMM: begin
				case (instr.rt)
					mipsIsaPkg::RT_BLTZ, mipsIsaPkg::RT_BLTZAL: begin
						branchCtrl.isBranch = 1'b1;
						if (isNeg) branchCtrl.npcOp = decodeCtrlPkg::NPC_BRANCH;
					end
					mipsIsaPkg::RT_BGEZ, mipsIsaPkg::RT_BGEZAL: begin
						branchCtrl.isBranch = 1'b1;
						if (!isNeg) branchCtrl.npcOp = decodeCtrlPkg::NPC_BRANCH;
					end
					default: ; // Traps and likely forms not handled
				endcase
			end
			mipsIsaPkg::OP_J, mipsIsaPkg::OP_JAL: begin
				branchCtrl.isBranch = 1'b1;
				branchCtrl.npcOp = decodeCtrlPkg::NPC_JUMP;
			end
			mipsIsaPkg::OP_SPECIAL: begin
				if (instr.funct == mipsIsaPkg::FN_JR || instr.funct == mipsIsaPkg::FN_JALR) begin
					branchCtrl.isBranch = 1'b1;
					branchCtrl.npcOp = decodeCtrlPkg::NPC_JREG; // Target from rs
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== hdl/writebackDecoder.sv ====
`timescale 1ns/100ps

module writebackDecoder (
	input  mipsIsaPkg::instrFields_t instr,
	output decodeCtrlPkg::wbCtrl_t   wbCtrl
);

	always_comb begin
		wbCtrl.regWrite = 1'b0;
		wbCtrl.regDst = decodeCtrlPkg::DST_RT;
		wbCtrl.wbSrc = decodeCtrlPkg::WB_ALU;
		case (instr.op)
			mipsIsaPkg::OP_SPECIAL: begin
				wbCtrl.regDst = decodeCtrlPkg::DST_RD;
				case (instr.funct)
					mipsIsaPkg::FN_ADD, mipsIsaPkg::FN_ADDU, mipsIsaPkg::FN_SUB,
					mipsIsaPkg::FN_SUBU, mipsIsaPkg::FN_AND, mipsIsaPkg::FN_OR,
					mipsIsaPkg::FN_XOR, mipsIsaPkg::FN_NOR, mipsIsaPkg::FN_SLT,
					mipsIsaPkg::FN_SLTU, mipsIsaPkg::FN_SLL, mipsIsaPkg::FN_SRL,
					mipsIsaPkg::FN_SRA, mipsIsaPkg::FN_SLLV, mipsIsaPkg::FN_SRLV,
					mipsIsaPkg::FN_SRAV: wbCtrl.regWrite = 1'b1;
					mipsIsaPkg::FN_MFHI: begin
						wbCtrl.regWrite = 1'b1;
						wbCtrl.wbSrc = decodeCtrlPkg::WB_HI;
					end
					mipsIsaPkg::FN_MFLO: begin
						wbCtrl.regWrite = 1'b1;
						wbCtrl.wbSrc = decodeCtrlPkg::WB_LO;
					end
					mipsIsaPkg::FN_JALR: begin
						wbCtrl.regWrite = 1'b1; // Link into rd
						wbCtrl.wbSrc = decodeCtrlPkg::WB_LINK;
					end
					default: ;
				endcase
			end
			mipsIsaPkg::OP_ADDI, mipsIsaPkg::OP_ADDIU, mipsIsaPkg::OP_SLTI,
			mipsIsaPkg::OP_SLTIU, mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI,
			mipsIsaPkg::OP_XORI, mipsIsaPkg::OP_LUI: wbCtrl.regWrite = 1'b1;
			mipsIsaPkg::OP_LB, mipsIsaPkg::OP_LBU, mipsIsaPkg::OP_LH,
			mipsIsaPkg::OP_LHU, mipsIsaPkg::OP_LW: begin
				wbCtrl.regWrite = 1'b1;
				wbCtrl.wbSrc = decodeCtrlPkg::WB_MEM;
			end
			mipsIsaPkg::OP_JAL: begin
				wbCtrl.regWrite = 1'b1;
				wbCtrl.regDst = decodeCtrlPkg::DST_LINK;
				wbCtrl.wbSrc = decodeCtrlPkg::WB_LINK;
			end
			mipsIsaPkg::OP_REGIMM: begin
				if (instr.rt == mipsIsaPkg::RT_BLTZAL || instr.rt == mipsIsaPkg::RT_BGEZAL) begin
					wbCtrl.regWrite = 1'b1; // Links whether taken or not
					wbCtrl.regDst = decodeCtrlPkg::DST_LINK;
					wbCtrl.wbSrc = decodeCtrlPkg::WB_LINK;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== hdl/exceptionDecoder.sv ====
`timescale 1ns/100ps

module exceptionDecoder (
	input  mipsIsaPkg::instrFields_t instr,
	input  logic                     ifFlush,
	input  decodeCtrlPkg::excInfo_t  upExc,
	input  logic                     known,
	output decodeCtrlPkg::excInfo_t  exc
);

	logic isSpecial;
	logic isBreak;
	logic isSyscall;

	assign isSpecial = instr.op == mipsIsaPkg::OP_SPECIAL;
	assign isBreak = isSpecial && instr.funct == mipsIsaPkg::FN_BREAK;
	assign isSyscall = isSpecial && instr.funct == mipsIsaPkg::FN_SYSCALL;

	always_comb begin
		if (upExc.valid) begin
			exc = upExc; // Fetch side fault wins
		end else if (!known && !isBreak && !isSyscall && !ifFlush) begin
			exc = '{valid: 1'b1, code: mipsIsaPkg::EXC_RI};
		end else if (isBreak) begin
			exc = '{valid: 1'b1, code: mipsIsaPkg::EXC_BP};
		end else if (isSyscall) begin
			exc = '{valid: 1'b1, code: mipsIsaPkg::EXC_SYS};
		end else begin
			exc = '{valid: 1'b0, code: mipsIsaPkg::EXC_NONE};
		end
	end

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        req,
	output logic                        ack,
	input  mipsIsaPkg::instrFields_t    instr,
	input  decodeCtrlPkg::cmpFlags_t    cmp,
	input  logic                        ifFlush,
	input  decodeCtrlPkg::excInfo_t     upExc,
	output decodeCtrlPkg::decodeCtrl_t  ctrl
);

	decodeCtrlPkg::aluCtrl_t    aluCtrl;
	decodeCtrlPkg::memCtrl_t    memCtrl;
	decodeCtrlPkg::branchCtrl_t branchCtrl;
	decodeCtrlPkg::wbCtrl_t     wbCtrl;
	decodeCtrlPkg::excInfo_t    exc;
	logic                       known;
	logic                       capture;

	aluDecoder aluDecoder_i (.instr(instr), .aluCtrl(aluCtrl));
	memDecoder memDecoder_i (.instr(instr), .memCtrl(memCtrl));
	branchResolver branchResolver_i (.instr(instr), .cmp(cmp), .branchCtrl(branchCtrl));
	writebackDecoder writebackDecoder_i (.instr(instr), .wbCtrl(wbCtrl));

	// Any decoder claiming the word makes it a legal instruction
	assign known = wbCtrl.regWrite | memCtrl.read | memCtrl.write
		| (aluCtrl.hiLoOp != decodeCtrlPkg::HILO_NONE) | branchCtrl.isBranch;

	exceptionDecoder exceptionDecoder_i (
		.instr(instr),
		.ifFlush(ifFlush),
		.upExc(upExc),
		.known(known),
		.exc(exc)
	);

	assign capture = req && !ack; // Phase 1 of the handshake

	always_ff @(posedge clk) begin
		if (!rst) begin
			ack <= 1'b0;
			ctrl <= '0; // No writes, sequential PC, no exception
		end else begin
			if (capture) begin
				ack <= 1'b1;
				ctrl <= '{alu: aluCtrl, mem: memCtrl, branch: branchCtrl, wb: wbCtrl, exc: exc};
			end else if (!req && ack) begin
				ack <= 1'b0; // ctrl holds until next capture
			end
		end
	end

endmodule

// ==== sim/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control bundle for one instruction word and its side inputs
function automatic decodeCtrlPkg::decodeCtrl_t expectedCtrl(mipsIsaPkg::instrFields_t w,
	decodeCtrlPkg::cmpFlags_t c, logic flush, decodeCtrlPkg::excInfo_t up);
	decodeCtrlPkg::decodeCtrl_t e;
	logic rType;
	logic load;
	logic store;
	logic link;
	logic take;
	logic known;
	logic brk;
	logic sys;
	e = '0;
	take = 1'b0;
	rType = w.op == mipsIsaPkg::OP_SPECIAL;
	load = w.op inside {mipsIsaPkg::OP_LB, mipsIsaPkg::OP_LBU, mipsIsaPkg::OP_LH,
		mipsIsaPkg::OP_LHU, mipsIsaPkg::OP_LW};
	store = w.op inside {mipsIsaPkg::OP_SB, mipsIsaPkg::OP_SH, mipsIsaPkg::OP_SW};
	link = w.op == mipsIsaPkg::OP_JAL || (w.op == mipsIsaPkg::OP_REGIMM
		&& w.rt inside {mipsIsaPkg::RT_BLTZAL, mipsIsaPkg::RT_BGEZAL});
	brk = rType && w.funct == mipsIsaPkg::FN_BREAK;
	sys = rType && w.funct == mipsIsaPkg::FN_SYSCALL;

	e.alu.aluOp = decodeCtrlPkg::ALU_NONE;
	e.alu.hiLoOp = decodeCtrlPkg::HILO_NONE;
	if (load || store)
		e.alu.aluOp = decodeCtrlPkg::ALU_ADD; // Effective address
	if (rType) begin
		case (w.funct)
			mipsIsaPkg::FN_ADD: e.alu.aluOp = decodeCtrlPkg::ALU_ADD;
			mipsIsaPkg::FN_ADDU: e.alu.aluOp = decodeCtrlPkg::ALU_ADDU;
			mipsIsaPkg::FN_SUB: e.alu.aluOp = decodeCtrlPkg::ALU_SUB;
			mipsIsaPkg::FN_SUBU: e.alu.aluOp = decodeCtrlPkg::ALU_SUBU;
			mipsIsaPkg::FN_AND: e.alu.aluOp = decodeCtrlPkg::ALU_AND;
			mipsIsaPkg::FN_OR: e.alu.aluOp = decodeCtrlPkg::ALU_OR;
			mipsIsaPkg::FN_XOR: e.alu.aluOp = decodeCtrlPkg::ALU_XOR;
			mipsIsaPkg::FN_NOR: e.alu.aluOp = decodeCtrlPkg::ALU_NOR;
			mipsIsaPkg::FN_SLT: e.alu.aluOp = decodeCtrlPkg::ALU_SLT;
			mipsIsaPkg::FN_SLTU: e.alu.aluOp = decodeCtrlPkg::ALU_SLTU;
			mipsIsaPkg::FN_SLL, mipsIsaPkg::FN_SLLV: e.alu.aluOp = decodeCtrlPkg::ALU_SLL;
			mipsIsaPkg::FN_SRL, mipsIsaPkg::FN_SRLV: e.alu.aluOp = decodeCtrlPkg::ALU_SRL;
			mipsIsaPkg::FN_SRA, mipsIsaPkg::FN_SRAV: e.alu.aluOp = decodeCtrlPkg::ALU_SRA;
			mipsIsaPkg::FN_MULT: e.alu.hiLoOp = decodeCtrlPkg::HILO_MULT;
			mipsIsaPkg::FN_MULTU: e.alu.hiLoOp = decodeCtrlPkg::HILO_MULTU;
			mipsIsaPkg::FN_DIV: e.alu.hiLoOp = decodeCtrlPkg::HILO_DIV;
			mipsIsaPkg::FN_DIVU: e.alu.hiLoOp = decodeCtrlPkg::HILO_DIVU;
			mipsIsaPkg::FN_MTHI: e.alu.hiLoOp = decodeCtrlPkg::HILO_MTHI;
			mipsIsaPkg::FN_MTLO: e.alu.hiLoOp = decodeCtrlPkg::HILO_MTLO;
			default: ;
		endcase
	end
	case (w.op)
		mipsIsaPkg::OP_ADDI: e.alu.aluOp = decodeCtrlPkg::ALU_ADD;
		mipsIsaPkg::OP_ADDIU: e.alu.aluOp = decodeCtrlPkg::ALU_ADDU;
		mipsIsaPkg::OP_SLTI: e.alu.aluOp = decodeCtrlPkg::ALU_SLT;
		mipsIsaPkg::OP_SLTIU: e.alu.aluOp = decodeCtrlPkg::ALU_SLTU;
		mipsIsaPkg::OP_ANDI: e.alu.aluOp = decodeCtrlPkg::ALU_AND;
		mipsIsaPkg::OP_ORI: e.alu.aluOp = decodeCtrlPkg::ALU_OR;
		mipsIsaPkg::OP_XORI: e.alu.aluOp = decodeCtrlPkg::ALU_XOR;
		mipsIsaPkg::OP_LUI: e.alu.aluOp = decodeCtrlPkg::ALU_LUI;
		default: ;
	endcase
	if (w.op inside {mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI, mipsIsaPkg::OP_XORI})
		e.alu.extOp = decodeCtrlPkg::EXT_ZERO;
	else if (w.op == mipsIsaPkg::OP_LUI)
		e.alu.extOp = decodeCtrlPkg::EXT_UPPER;
	else
		e.alu.extOp = decodeCtrlPkg::EXT_SIGN;
	e.alu.shamtSel = rType && w.funct inside {mipsIsaPkg::FN_SLL, mipsIsaPkg::FN_SRL,
		mipsIsaPkg::FN_SRA};

	e.mem.read = load;
	e.mem.write = store;
	e.mem.isSigned = w.op inside {mipsIsaPkg::OP_LB, mipsIsaPkg::OP_LH};
	if (w.op inside {mipsIsaPkg::OP_LW, mipsIsaPkg::OP_SW})
		e.mem.size = decodeCtrlPkg::MEM_WORD;
	else if (w.op inside {mipsIsaPkg::OP_LH, mipsIsaPkg::OP_LHU, mipsIsaPkg::OP_SH})
		e.mem.size = decodeCtrlPkg::MEM_HALF;
	else
		e.mem.size = decodeCtrlPkg::MEM_BYTE;

	// Taken rules from the compare flags
	e.branch.isBranch = 1'b1;
	e.branch.npcOp = decodeCtrlPkg::NPC_SEQ;
	case (w.op)
		mipsIsaPkg::OP_BEQ: take = !c.neq;
		mipsIsaPkg::OP_BNE: take = c.neq;
		mipsIsaPkg::OP_BLEZ: take = c.sign != decodeCtrlPkg::SIGN_POS;
		mipsIsaPkg::OP_BGTZ: take = c.sign == decodeCtrlPkg::SIGN_POS;
		mipsIsaPkg::OP_REGIMM: begin
			if (w.rt inside {mipsIsaPkg::RT_BLTZ, mipsIsaPkg::RT_BLTZAL})
				take = c.sign == decodeCtrlPkg::SIGN_NEG;
			else if (w.rt inside {mipsIsaPkg::RT_BGEZ, mipsIsaPkg::RT_BGEZAL})
				take = c.sign != decodeCtrlPkg::SIGN_NEG;
			else
				e.branch.isBranch = 1'b0;
		end
		mipsIsaPkg::OP_J, mipsIsaPkg::OP_JAL: e.branch.npcOp = decodeCtrlPkg::NPC_JUMP;
		mipsIsaPkg::OP_SPECIAL: begin
			if (w.funct inside {mipsIsaPkg::FN_JR, mipsIsaPkg::FN_JALR})
				e.branch.npcOp = decodeCtrlPkg::NPC_JREG;
			else
				e.branch.isBranch = 1'b0;
		end
		default: e.branch.isBranch = 1'b0;
	endcase
	if (take)
		e.branch.npcOp = decodeCtrlPkg::NPC_BRANCH;

	e.wb.regWrite = load || link || (e.alu.aluOp != decodeCtrlPkg::ALU_NONE && !store)
		|| (rType && w.funct inside {mipsIsaPkg::FN_MFHI, mipsIsaPkg::FN_MFLO,
		mipsIsaPkg::FN_JALR});
	e.wb.regDst = decodeCtrlPkg::DST_RT;
	if (rType)
		e.wb.regDst = decodeCtrlPkg::DST_RD;
	else if (link)
		e.wb.regDst = decodeCtrlPkg::DST_LINK; // Writes LINK_REG
	e.wb.wbSrc = decodeCtrlPkg::WB_ALU;
	if (load)
		e.wb.wbSrc = decodeCtrlPkg::WB_MEM;
	else if (link || (rType && w.funct == mipsIsaPkg::FN_JALR))
		e.wb.wbSrc = decodeCtrlPkg::WB_LINK;
	else if (rType && w.funct == mipsIsaPkg::FN_MFHI)
		e.wb.wbSrc = decodeCtrlPkg::WB_HI;
	else if (rType && w.funct == mipsIsaPkg::FN_MFLO)
		e.wb.wbSrc = decodeCtrlPkg::WB_LO;

	// Upstream fault first, then RI, Bp, Sys
	known = e.wb.regWrite || load || store || e.branch.isBranch
		|| e.alu.hiLoOp != decodeCtrlPkg::HILO_NONE;
	if (up.valid)
		e.exc = up;
	else if (!known && !brk && !sys && !flush)
		e.exc = '{valid: 1'b1, code: mipsIsaPkg::EXC_RI};
	else if (brk)
		e.exc = '{valid: 1'b1, code: mipsIsaPkg::EXC_BP};
	else if (sys)
		e.exc = '{valid: 1'b1, code: mipsIsaPkg::EXC_SYS};
	else
		e.exc = '{valid: 1'b0, code: mipsIsaPkg::EXC_NONE};
	return e;
endfunction

`endif

// ==== sim/tbDecodeStage.sv ====
`timescale 1ns/100ps

module tbDecodeStage;

	`include "decodeModel.svh"

	localparam int NUM_TX = 2000;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES = RESET_CYCLES + NUM_TX * 5; // At most 3 cycles per transaction
	localparam int NUM_TESTS = 6;

	logic clk;
	logic rst;
	logic req;
	logic ack;
	mipsIsaPkg::instrFields_t instr;
	decodeCtrlPkg::cmpFlags_t cmp;
	logic ifFlush;
	decodeCtrlPkg::excInfo_t upExc;
	decodeCtrlPkg::decodeCtrl_t ctrl;

	int cycles = 0;
	int checks [NUM_TESTS];
	int errors [NUM_TESTS];
	string testNames [NUM_TESTS] = '{"handshake", "alu", "mem", "branch", "writeback",
		"exception"};

	decodeStage dut_i (.clk(clk), .rst(rst), .req(req), .ack(ack), .instr(instr), .cmp(cmp),
		.ifFlush(ifFlush), .upExc(upExc), .ctrl(ctrl));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic checkField(input int test, input string name, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		checks[test]++;
		if (gotVal !== expVal) begin
			errors[test]++;
			$display("[FAIL] t=%0d ns %s expected %h got %h", $time, name, expVal, gotVal);
		end
	endtask

	// Ack must reach the level one edge after req was sampled
	task automatic waitAck(input logic level);
		int edges;
		edges = 0;
		do begin
			@(posedge clk);
			#1;
			edges++;
		end while (ack !== level && edges < 8);
		if (ack !== level) begin
			errors[0]++;
			$display("ack never went to %0b within %0d cycles of the req change", level, edges);
		end else begin
			checkField(0, "ack latency", 32'(1), 32'(edges));
		end
	endtask

	// Kept encoding with random fields, or a fully random word
	function automatic mipsIsaPkg::instrFields_t pickInstr();
		mipsIsaPkg::instrFields_t w;
		mipsIsaPkg::opcode_t op;
		mipsIsaPkg::funct_t fn;
		mipsIsaPkg::regimm_t ri;
		int kind;
		w = $urandom;
		kind = $urandom % 8;
		op = op.first();
		repeat ($urandom % op.num()) op = op.next();
		fn = fn.first();
		repeat ($urandom % fn.num()) fn = fn.next();
		ri = ri.first();
		repeat ($urandom % ri.num()) ri = ri.next();
		if (kind >= 2 && kind <= 4) begin
			w.op = mipsIsaPkg::OP_SPECIAL;
			w.funct = fn;
		end else if (kind == 5) begin
			w.op = mipsIsaPkg::OP_REGIMM;
			w.rt = ri;
		end else if (kind >= 6) begin
			w.op = op;
		end
		return w;
	endfunction

	task automatic runTransaction();
		decodeCtrlPkg::decodeCtrl_t exp;
		decodeCtrlPkg::decodeCtrl_t held;
		instr = pickInstr();
		cmp.neq = 1'($urandom);
		cmp.sign = decodeCtrlPkg::sign_t'(2'($urandom % 3));
		ifFlush = ($urandom % 4) == 0;
		upExc.valid = ($urandom % 8) == 0;
		upExc.code = mipsIsaPkg::excCode_t'(5'($urandom));
		exp = expectedCtrl(instr, cmp, ifFlush, upExc);
		req = 1'b1;
		waitAck(1'b1);
		checkField(1, "ctrl.alu", 32'(exp.alu), 32'(ctrl.alu));
		checkField(2, "ctrl.mem", 32'(exp.mem), 32'(ctrl.mem));
		checkField(3, "ctrl.branch", 32'(exp.branch), 32'(ctrl.branch));
		checkField(4, "ctrl.wb", 32'(exp.wb), 32'(ctrl.wb));
		checkField(5, "ctrl.exc", 32'(exp.exc), 32'(ctrl.exc));
		held = ctrl;
		repeat ($urandom % 2) begin
			@(posedge clk);
			#1;
			checkField(0, "ack while req high", 32'(1), 32'(ack));
			checkField(0, "ctrl while req high", 32'(held), 32'(ctrl));
		end
		req = 1'b0;
		instr = pickInstr(); // Upstream may move on once req is low
		waitAck(1'b0);
		checkField(0, "ctrl after ack low", 32'(held), 32'(ctrl));
	endtask

	initial begin
		int errorTotal;
		int checkTotal;
		void'($urandom(2));
		rst = 1'b0;
		req = 1'b0;
		instr = '0;
		cmp = '0;
		ifFlush = 1'b0;
		upExc = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		checkField(0, "ack after reset", 32'(0), 32'(ack));
		checkField(0, "ctrl after reset", 32'(0), 32'(ctrl)); // All zero bundle
		rst = 1'b1;
		for (int i = 0; i < NUM_TX; i++) begin
			runTransaction();
		end
		errorTotal = 0;
		checkTotal = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			$display("Test %s done: %0d checks, %0d errors", testNames[t], checks[t], errors[t]);
			errorTotal += errors[t];
			checkTotal += checks[t];
		end
		$display("Totals: %0d tests, %0d transactions, %0d checks, %0d errors", NUM_TESTS,
			NUM_TX, checkTotal, errorTotal);
		if (errorTotal == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+sim
hdl/mipsIsaPkg.sv
hdl/decodeCtrlPkg.sv
hdl/aluDecoder.sv
hdl/memDecoder.sv
hdl/branchResolver.sv
hdl/writebackDecoder.sv
hdl/exceptionDecoder.sv
hdl/decodeStage.sv
sim/tbDecodeStage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module tbDecodeStage > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/VtbDecodeStage > sim.log 2>&1
cat sim.log
grep -qx "Simulation passed" sim.log && echo "run.sh: PASS" \
	|| { echo "run.sh: FAIL, see sim.log"; exit 1; }
